// ==== logic/minerPkg.sv ====
package minerPkg;

    // sha-256 word and the wider values built from words
    typedef logic [31:0]  word_t;
    typedef logic [255:0] digest_t;
    typedef logic [511:0] block_t;
    // header without its trailing nonce
    typedef logic [607:0] header_t;
    // required leading zeros, 0 to 32
    typedef logic [5:0]   zeroCount_t;

    typedef enum logic [2:0] {
        idle,
        midstate,
        compress,
        check,
        done
    } searchState_t;

    // full header length in bits, goes into the padding
    localparam int headerBits = 640;

    // each display digit stays lit for 2**scanBits clocks
    localparam int scanBits = 10;

    // initial chaining value, word a in the top bits
    localparam digest_t hashInit = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    localparam word_t roundK [0:63] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // bit order {dp, g, f, e, d, c, b, a}, low lights the segment
    // dp stays dark
    localparam logic [7:0] hexSegments [0:15] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
    };

endpackage

// ==== logic/sha256Core.sv ====
`timescale 1ns/1ps

module sha256Core (
    input  logic              clock,
    input  logic              rst,
    input  logic              hashReq,
    output logic              hashAck,
    input  minerPkg::digest_t chainIn,
    input  minerPkg::block_t  block,
    output minerPkg::digest_t chainOut
);
    import minerPkg::*;

    // working variables
    word_t a, b, c, d, e, f, g, h;
    // sliding schedule window, w[0] is the word of the current round
    word_t w [0:15];
    logic [5:0] round;
    logic busy;

    word_t t1;
    word_t t2;
    word_t nextW;
    digest_t nextVars;

    function automatic word_t rotr(input word_t x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic word_t bigSigma0(input word_t x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic word_t bigSigma1(input word_t x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    function automatic word_t smallSigma0(input word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t smallSigma1(input word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    // one round of the compression
    always_comb begin
        t1 = h + bigSigma1(e) + ((e & f) ^ (~e & g)) + roundK[round] + w[0];
        t2 = bigSigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
        // word sixteen ahead of the current one
        nextW = smallSigma1(w[14]) + w[9] + smallSigma0(w[1]) + w[0];
        nextVars = {t1 + t2, a, b, c, d + t1, e, f, g};
    end

    // handshake and round count
    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
            hashAck <= 1'b0;
            round <= '0;
        end else if (hashAck) begin
            // result held until the request drops
            if (!hashReq) begin
                hashAck <= 1'b0;
            end
        end else if (busy) begin
            round <= round + 6'd1;
            if (round == 6'd63) begin
                busy <= 1'b0;
                hashAck <= 1'b1;
            end
        end else if (hashReq) begin
            // load cycle
            busy <= 1'b1;
            round <= '0;
        end
    end

    // datapath
    always_ff @(posedge clock) begin
        if (!busy && !hashAck && hashReq) begin
            {a, b, c, d, e, f, g, h} <= chainIn;
            for (int i = 0; i < 16; i++) begin
                w[i] <= block[511 - 32 * i -: 32];
            end
        end else if (busy) begin
            {a, b, c, d, e, f, g, h} <= nextVars;
            for (int i = 0; i < 15; i++) begin
                w[i] <= w[i + 1];
            end
            w[15] <= nextW;
            // feed-forward in the last round
            if (round == 6'd63) begin
                for (int i = 0; i < 8; i++) begin
                    chainOut[255 - 32 * i -: 32] <=
                        chainIn[255 - 32 * i -: 32] + nextVars[255 - 32 * i -: 32];
                end
            end
        end
    end

endmodule

// ==== logic/nonceSearch.sv ====
`timescale 1ns/1ps

module nonceSearch (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 startReq,
    output logic                 startAck,
    input  minerPkg::header_t    header,
    input  minerPkg::zeroCount_t zeroBits,
    output logic                 hashReq,
    input  logic                 hashAck,
    output minerPkg::digest_t    chainIn,
    output minerPkg::block_t     block,
    input  minerPkg::digest_t    chainOut,
    output minerPkg::word_t      foundNonce,
    output minerPkg::digest_t    foundHash,
    output logic                 led
);
    import minerPkg::*;

    searchState_t state;
    word_t nonce;
    digest_t midHash;
    word_t zeroMask;
    logic hit;

    // first block from the fixed header, second block padded around the nonce
    assign chainIn = (state == midstate) ? hashInit : midHash;
    assign block = (state == midstate) ? header[607:96]
                 : {header[95:0], nonce, 1'b1, 319'b0, 64'(headerBits)};

    // top zeroBits bits of the hash must be clear
    assign zeroMask = ~({32{1'b1}} >> zeroBits);
    assign hit = (chainOut[255:224] & zeroMask) == '0;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= idle;
            startAck <= 1'b0;
            hashReq <= 1'b0;
            led <= 1'b0;
            nonce <= '0;
            foundNonce <= '0;
        end else begin
            case (state)
                idle: begin
                    if (startReq) begin
                        nonce <= '0;
                        led <= 1'b0;
                        hashReq <= 1'b1;
                        state <= midstate;
                    end
                end
                midstate: begin
                    if (hashAck) begin
                        hashReq <= 1'b0;
                        state <= compress;
                    end
                end
                compress: begin
                    // wait out the previous ack before a new request
                    if (!hashReq && !hashAck) begin
                        hashReq <= 1'b1;
                    end else if (hashReq && hashAck) begin
                        hashReq <= 1'b0;
                        state <= check;
                    end
                end
                check: begin
                    if (hit) begin
                        foundNonce <= nonce;
                        startAck <= 1'b1;
                        led <= 1'b1;
                        state <= done;
                    end else begin
                        nonce <= nonce + 32'd1;
                        state <= compress;
                    end
                end
                done: begin
                    // host closes the handshake
                    if (!startReq) begin
                        startAck <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // result and midstate capture
    always_ff @(posedge clock) begin
        if (state == midstate && hashAck) begin
            midHash <= chainOut;
        end
        if (state == check && hit) begin
            foundHash <= chainOut;
        end
    end

endmodule

// ==== logic/segmentScan.sv ====
`timescale 1ns/1ps

module segmentScan (
    input  logic            clock,
    input  logic            rst,
    input  minerPkg::word_t value,
    output logic [7:0]      ca,
    output logic [7:0]      an
);
    import minerPkg::*;

    // top three bits pick the digit
    logic [scanBits + 2:0] scanCount;
    logic [2:0] digit;
    logic [3:0] nibble;

    always_ff @(posedge clock) begin
        if (rst) begin
            scanCount <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    assign digit = scanCount[scanBits + 2:scanBits];

    // digit 0 is the least significant nibble
    assign nibble = value[4 * digit +: 4];

    // one anode low at a time
    assign an = ~(8'b0000_0001 << digit);
    assign ca = hexSegments[nibble];

endmodule

// ==== logic/minerTop.sv ====
`timescale 1ns/1ps

module minerTop (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 startReq,
    output logic                 startAck,
    input  minerPkg::header_t    header,
    input  minerPkg::zeroCount_t zeroBits,
    output minerPkg::word_t      foundNonce,
    output minerPkg::digest_t    foundHash,
    output logic                 led,
    output logic [7:0]           ca,
    output logic [7:0]           an
);
    import minerPkg::*;

    // search to core handshake
    logic hashReq;
    logic hashAck;
    digest_t chainIn;
    block_t block;
    digest_t chainOut;

    nonceSearch i_nonceSearch (
        .clock      (clock),
        .rst        (rst),
        .startReq   (startReq),
        .startAck   (startAck),
        .header     (header),
        .zeroBits   (zeroBits),
        .hashReq    (hashReq),
        .hashAck    (hashAck),
        .chainIn    (chainIn),
        .block      (block),
        .chainOut   (chainOut),
        .foundNonce (foundNonce),
        .foundHash  (foundHash),
        .led        (led)
    );

    sha256Core i_sha256Core (
        .clock    (clock),
        .rst      (rst),
        .hashReq  (hashReq),
        .hashAck  (hashAck),
        .chainIn  (chainIn),
        .block    (block),
        .chainOut (chainOut)
    );

    // latched nonce on the display
    segmentScan i_segmentScan (
        .clock (clock),
        .rst   (rst),
        .value (foundNonce),
        .ca    (ca),
        .an    (an)
    );

endmodule

// ==== include/sha256Model.svh ====
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

function automatic minerPkg::word_t modelRotr(input minerPkg::word_t x, input int n);
    return (x >> n) | (x << (32 - n));
endfunction

// one full compression including the feed-forward
function automatic minerPkg::digest_t modelCompress(input minerPkg::digest_t chain,
                                                    input minerPkg::block_t blk);
    minerPkg::word_t w [0:63];
    minerPkg::word_t v [0:7];
    minerPkg::word_t s0, s1, t1, t2;
    minerPkg::digest_t result;
    for (int i = 0; i < 16; i++) begin
        w[i] = blk[511 - 32 * i -: 32];
    end
    // full expanded schedule up front
    for (int i = 16; i < 64; i++) begin
        s0 = modelRotr(w[i - 15], 7) ^ modelRotr(w[i - 15], 18) ^ (w[i - 15] >> 3);
        s1 = modelRotr(w[i - 2], 17) ^ modelRotr(w[i - 2], 19) ^ (w[i - 2] >> 10);
        w[i] = w[i - 16] + s0 + w[i - 7] + s1;
    end
    for (int i = 0; i < 8; i++) begin
        v[i] = chain[255 - 32 * i -: 32];
    end
    for (int i = 0; i < 64; i++) begin
        s1 = modelRotr(v[4], 6) ^ modelRotr(v[4], 11) ^ modelRotr(v[4], 25);
        t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + minerPkg::roundK[i] + w[i];
        s0 = modelRotr(v[0], 2) ^ modelRotr(v[0], 13) ^ modelRotr(v[0], 22);
        t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        for (int j = 7; j > 0; j--) begin
            v[j] = v[j - 1];
        end
        v[4] = v[4] + t1;
        v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
        result[255 - 32 * i -: 32] = chain[255 - 32 * i -: 32] + v[i];
    end
    return result;
endfunction

// single sha-256 of the 80-byte header with nonce in the last word
function automatic minerPkg::digest_t modelHeaderHash(input minerPkg::header_t hdr,
                                                      input minerPkg::word_t nonce);
    minerPkg::digest_t mid;
    mid = modelCompress(minerPkg::hashInit, hdr[607:96]);
    // 80 bytes of message, so the length field holds 640
    return modelCompress(mid, {hdr[95:0], nonce, 1'b1, 319'b0, 64'd640});
endfunction

// true when the top zeroBits bits of the hash are clear
function automatic bit modelMeetsZeros(input minerPkg::digest_t hash,
                                       input minerPkg::zeroCount_t zeroBits);
    bit ok;
    ok = 1'b1;
    // walk down from the most significant hash bit
    for (int i = 0; i < zeroBits; i++) begin
        if (hash[255 - i]) ok = 1'b0;
    end
    return ok;
endfunction

`endif

// ==== test/minerTb.sv ====
`timescale 1ns/1ps

module minerTb;
    import minerPkg::*;
    `include "sha256Model.svh"

    logic clock;
    logic rst;
    logic startReq;
    logic startAck;
    header_t header;
    zeroCount_t zeroBits;
    word_t foundNonce;
    digest_t foundHash;
    logic led;
    logic [7:0] ca;
    logic [7:0] an;

    int errors = 0;
    int searches = 0;
    bit timedOut = 1'b0;
    word_t seed = 32'hbc4a9e12;
    word_t lastNonce;
    header_t hdr;

    minerTop i_minerTop (
        .clock      (clock),
        .rst        (rst),
        .startReq   (startReq),
        .startAck   (startAck),
        .header     (header),
        .zeroBits   (zeroBits),
        .foundNonce (foundNonce),
        .foundHash  (foundHash),
        .led        (led),
        .ca         (ca),
        .an         (an)
    );

    always #20 clock = ~clock;

    // xorshift32
    function automatic word_t randWord();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic header_t randHeader();
        header_t h;
        for (int i = 0; i < 19; i++) begin
            h[32 * i +: 32] = randWord();
        end
        return h;
    endfunction

    task automatic reportMismatch(input string test, input logic [255:0] exp,
                                  input logic [255:0] act);
        $display("FAIL %s expected %0h actual %0h", test, exp, act);
        errors++;
    endtask

    task automatic reportAndStop();
        $display("searches %0d, errors %0d", searches, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // one host transaction, checked against the model's own nonce walk
    task automatic runSearch(input string name, input header_t h, input zeroCount_t zb,
                             input int hold, output word_t expNonce);
        digest_t expHash;
        word_t held;
        int cnt;
        int limit;
        expNonce = '0;
        while (!modelMeetsZeros(modelHeaderHash(h, expNonce), zb)) begin
            expNonce++;
        end
        expHash = modelHeaderHash(h, expNonce);
        header = h;
        zeroBits = zb;
        startReq = 1'b1;
        searches++;
        @(negedge clock);
        if (led !== 1'b0) reportMismatch({name, " led on start"}, 0, led);
        // about 67 cycles per compression plus slack
        limit = (expNonce + 2) * 80 + 100;
        cnt = 0;
        while (startAck !== 1'b1 && cnt < limit) begin
            @(negedge clock);
            cnt++;
        end
        if (startAck !== 1'b1) begin
            $display("startAck did not rise within %0d cycles in %s", limit, name);
            errors++;
            timedOut = 1'b1;
        end else begin
            if (foundNonce !== expNonce) reportMismatch({name, " nonce"}, expNonce, foundNonce);
            if (foundHash !== expHash) reportMismatch({name, " hash"}, expHash, foundHash);
            if (led !== 1'b1) reportMismatch({name, " led"}, 1, led);
            held = foundNonce;
            // host holds the request a little longer
            repeat (hold) begin
                @(negedge clock);
                if (startAck !== 1'b1) reportMismatch({name, " ack held"}, 1, startAck);
                if (foundNonce !== held) reportMismatch({name, " nonce held"}, held, foundNonce);
            end
            startReq = 1'b0;
            cnt = 0;
            while (startAck !== 1'b0 && cnt < 10) begin
                @(negedge clock);
                cnt++;
            end
            if (startAck !== 1'b0) begin
                $display("startAck did not fall after startReq dropped in %s", name);
                errors++;
                timedOut = 1'b1;
            end else begin
                if (led !== 1'b1) reportMismatch({name, " led after ack"}, 1, led);
                if (foundNonce !== held) reportMismatch({name, " nonce kept"}, held, foundNonce);
            end
        end
    endtask

    // one full scan of eight digits
    task automatic checkDisplay(input string name, input word_t expNonce);
        int k;
        logic [7:0] seen;
        bit bad;
        seen = '0;
        bad = 1'b0;
        for (int c = 0; c < 8 * 1024 && !bad; c++) begin
            @(negedge clock);
            k = -1;
            for (int i = 0; i < 8; i++) begin
                if (an == ~(8'h01 << i)) k = i;
            end
            if (k < 0) begin
                $display("anode pattern %b is not one-hot active low in %s", an, name);
                errors++;
                bad = 1'b1;
            end else begin
                seen[k] = 1'b1;
                if (ca !== hexSegments[expNonce[4 * k +: 4]]) begin
                    reportMismatch($sformatf("%s digit %0d", name, k),
                                   hexSegments[expNonce[4 * k +: 4]], ca);
                    bad = 1'b1;
                end
            end
        end
        if (!bad && seen !== 8'hff) reportMismatch({name, " digits seen"}, 8'hff, seen);
    endtask

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        startReq = 1'b0;
        header = '0;
        zeroBits = '0;
        repeat (10) @(negedge clock);
        rst = 1'b0;
        @(negedge clock);
        if (startAck !== 1'b0) reportMismatch("reset startAck", 0, startAck);
        if (led !== 1'b0) reportMismatch("reset led", 0, led);
        if (an !== 8'hfe) reportMismatch("reset an", 8'hfe, an);
        if (ca !== hexSegments[0]) reportMismatch("reset ca", hexSegments[0], ca);
        // zero difficulty always stops at nonce 0
        for (int i = 0; i < 2 && !timedOut; i++) begin
            runSearch("zeroDifficulty", randHeader(), 6'd0, 0, lastNonce);
        end
        for (int i = 0; i < 3 && !timedOut; i++) begin
            hdr = randHeader();
            runSearch("difficulty", hdr, zeroCount_t'(4 + randWord() % 5),
                      1 + randWord() % 16, lastNonce);
            if (i == 0 && !timedOut) checkDisplay("display", lastNonce);
        end
        // new headers straight after each other
        for (int i = 0; i < 2 && !timedOut; i++) begin
            hdr = randHeader();
            runSearch("backToBack", hdr, zeroCount_t'(4 + randWord() % 5), 0, lastNonce);
        end
        reportAndStop();
    end

endmodule

// ==== sim.f ====
+incdir+include
logic/minerPkg.sv
logic/sha256Core.sv
logic/nonceSearch.sv
logic/segmentScan.sv
logic/minerTop.sv
test/minerTb.sv
